// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = iomux_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Something failed
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	   echo "RESULT: FAIL, run ended early"; exit 1; \
	else \
	   echo "RESULT: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
+incdir+sim
verilog/iomux_pkg.sv
verilog/port_b_func.sv
verilog/port_d_func.sv
verilog/pin_mux.sv
verilog/iomux_top.sv
sim/iomux_assertions.sv
sim/iomux_tb.sv

// ==== sim/iomux_assertions.sv ====
`timescale 1ns/10ps

module iomux_assertions (
   input logic                          clk,
   input logic                          rst_n,
   input iomux_pkg::spi_ctrl_t          spi,
   input iomux_pkg::uart_ctrl_t         uart,
   input iomux_pkg::xb_ovr_t            xb,
   input logic [iomux_pkg::PORTD_W-1:0] portd_pad_oe
);
   import iomux_pkg::*;

   // MISO data only comes from an enabled slave
   a_misoo_slave: assert property (@(posedge clk) disable iff (!rst_n)
      spi.misoo |-> (spi.spe && !spi.spimaster))
      else $error("misoo set outside SPI slave mode");

   a_txd_out: assert property (@(posedge clk) disable iff (!rst_n)
      uart.tx_en |-> portd_pad_oe[1])                  // Transmitter drives PD1
      else $error("PD1 not an output with tx_en set");

   // Receiver keeps PD0 an input unless xb takes the direction
   a_rxd_in: assert property (@(posedge clk) disable iff (!rst_n)
      (uart.rx_en && !xb.ddoe[XB_PORTD_LSB]) |-> !portd_pad_oe[0])
      else $error("PD0 driven with rx_en set");

endmodule

bind iomux_top iomux_assertions u_assertions (
   .clk          (clk),
   .rst_n        (rst_n),
   .spi          (spi),
   .uart         (uart),
   .xb           (xb),
   .portd_pad_oe (portd_pad_oe)
);

// ==== sim/iomux_tests.svh ====
// Expected read values per port, checked against every receive output
task automatic check_receive(input logic [5:0] exp_b, input logic [7:0] exp_d);
   logic [23:0] exp_pc;
   exp_pc        = '0;
   exp_pc[5:0]   = exp_b;                               // PCINT5:0
   exp_pc[23:16] = exp_d;                               // PCINT23:16
   check_value("pcint_rcv", pcint_rcv, exp_pc);
   check_value("spi_rcv", spi_rcv, exp_b[5:2]);
   check_value("icp1_pin", icp1_pin, exp_b[0]);
   check_value("t1_pin", t1_pin, exp_d[5]);
   check_value("t0_pin", t0_pin, exp_d[4]);
   check_value("xck_rcv", xck_rcv, exp_d[4]);
   check_value("int1_rcv", int1_rcv, exp_d[3]);
   check_value("int0_rcv", int0_rcv, exp_d[2]);
   check_value("rxd_rcv", rxd_rcv, exp_d[0]);
endtask

task automatic test_gpio_default();
   int          i;
   logic [31:0] r;
   for (i = 0; i < 8; i++) begin
      drive_edge();
      clear_inputs();
      r            = next_rand();
      gpio_b       = r[11:0];
      gpio_d       = r[27:12];
      r            = next_rand();
      portb_pad_in = r[5:0];
      portd_pad_in = r[13:6];
      sample_point();
      check_value("portb_pad_oe", portb_pad_oe, gpio_b.ddrx);   // Registers only
      check_value("portb_pad_out", portb_pad_out, gpio_b.portx);
      check_value("portd_pad_oe", portd_pad_oe, gpio_d.ddrx);
      check_value("portd_pad_out", portd_pad_out, gpio_d.portx);
      check_value("xb_pinx", xb_pinx, {6'b0, portb_pad_in, portd_pad_in});
      check_value("pin13_led", pin13_led, portb_pad_in[5]);
      check_receive(portb_pad_in, portd_pad_in);        // Awake, all inputs live
   end
endtask

task automatic test_sleep_gating();
   int          i;
   logic [31:0] r;
   logic [5:0]  en_b;
   logic [7:0]  en_d;
   // INT enables alone, no pin-change mask
   drive_edge();
   clear_inputs();
   sleep        = 1'b1;
   pcie         = '1;
   int0_enable  = 1'b1;
   int1_enable  = 1'b1;
   portb_pad_in = '1;
   portd_pad_in = '1;
   sample_point();
   check_value("pcint_rcv", pcint_rcv, 24'h0c_0000);     // PD3 and PD2 only
   check_value("int0_rcv", int0_rcv, 1'b1);
   check_value("int1_rcv", int1_rcv, 1'b1);
   for (i = 0; i < 8; i++) begin
      drive_edge();
      clear_inputs();
      sleep        = 1'b1;
      r            = next_rand();
      pcint_irq    = r[23:0];
      pcie         = r[26:24];
      int0_enable  = r[27];
      int1_enable  = r[28];
      r            = next_rand();
      portb_pad_in = r[5:0];
      portd_pad_in = r[13:6];
      // Mask and enable keep a pin readable in sleep
      en_b    = pcint_irq[5:0] & {6{pcie.pcie0}};
      en_d    = pcint_irq[23:16] & {8{pcie.pcie2}};
      en_d[2] = (pcint_irq[18] & pcie.pcie1) | int0_enable;    // PD2 on pcie1
      en_d[3] = en_d[3] | int1_enable;
      sample_point();
      check_receive(portb_pad_in & en_b, portd_pad_in & en_d);
      check_value("pin13_led", pin13_led, portb_pad_in[5]);    // Raw pad tap
   end
endtask

// One step on PB1 (OC1A) or PD6 (OC0A)
task automatic drive_priority(input logic on_b, input logic reg_v, input logic oc_en,
                              input logic oc_pin, input logic xb_oe, input logic xb_v);
   drive_edge();
   clear_inputs();
   if (on_b) begin
      gpio_b.portx[1]            = reg_v;
      oc1a.enable                = oc_en;
      oc1a.pin                   = oc_pin;
      xb.pvoe[XB_PORTB_LSB + 1]  = xb_oe;
      xb.pvov[XB_PORTB_LSB + 1]  = xb_v;
   end else begin
      gpio_d.portx[6]            = reg_v;
      oc0a.enable                = oc_en;
      oc0a.pin                   = oc_pin;
      xb.pvoe[XB_PORTD_LSB + 6]  = xb_oe;
      xb.pvov[XB_PORTD_LSB + 6]  = xb_v;
   end
   sample_point();
endtask

task automatic check_priority_out(input logic on_b, input logic expected);
   if (on_b) begin
      check_value("portb_pad_out[1]", portb_pad_out[1], expected);
   end else begin
      check_value("portd_pad_out[6]", portd_pad_out[6], expected);
   end
endtask

task automatic test_override_priority();
   int   i;
   int   side;
   logic on_b;
   for (side = 0; side < 2; side++) begin
      on_b = (side == 0);
      drive_priority(on_b, 1, 0, 0, 0, 0);               // Register alone
      check_priority_out(on_b, 1'b1);
      drive_priority(on_b, 1, 1, 0, 0, 0);               // Peripheral beats register
      check_priority_out(on_b, 1'b0);
      drive_priority(on_b, 0, 1, 1, 0, 0);
      check_priority_out(on_b, 1'b1);
      drive_priority(on_b, 1, 1, 0, 1, 1);               // xb beats both
      check_priority_out(on_b, 1'b1);
      drive_priority(on_b, 1, 0, 0, 1, 0);
      check_priority_out(on_b, 1'b0);
      drive_priority(on_b, 0, 1, 1, 1, 0);               // Both overrides, values or'ed
      check_priority_out(on_b, 1'b1);
   end
   // OC2A, OC1B, OC0B and OC2B win over portx
   for (i = 0; i < 2; i++) begin
      drive_edge();
      clear_inputs();
      gpio_b.portx = i[0] ? 6'h00 : 6'h3f;               // Register holds the other value
      gpio_d.portx = i[0] ? 8'h00 : 8'hff;
      oc2a         = {1'b1, i[0]};
      oc1b         = {1'b1, i[0]};
      oc0b         = {1'b1, i[0]};
      oc2b         = {1'b1, i[0]};
      sample_point();
      check_value("portb_pad_out[3]", portb_pad_out[3], i[0]);
      check_value("portb_pad_out[2]", portb_pad_out[2], i[0]);
      check_value("portd_pad_out[5]", portd_pad_out[5], i[0]);
      check_value("portd_pad_out[3]", portd_pad_out[3], i[0]);
   end
   // Direction from xb over ddrx on every pin
   drive_edge();
   clear_inputs();
   gpio_b.ddrx = '1;
   gpio_d.ddrx = '1;
   xb.ddoe     = '1;
   sample_point();
   check_value("portb_pad_oe", portb_pad_oe, 6'h00);
   check_value("portd_pad_oe", portd_pad_oe, 8'h00);
endtask

task automatic test_spi();
   int          i;
   logic [31:0] r;
   // Master, MISO bit of ddrx ignored
   for (i = 0; i < 4; i++) begin
      drive_edge();
      clear_inputs();
      spi.spe       = 1'b1;
      spi.spimaster = 1'b1;
      spi.scko      = i[0];
      spi.mosio     = i[1];
      gpio_b.ddrx   = 6'b011000;
      r             = next_rand();
      portb_pad_in  = r[5:0];
      sample_point();
      check_value("portb_pad_oe[5]", portb_pad_oe[5], 1'b1);
      check_value("portb_pad_out[5]", portb_pad_out[5], i[0]);
      check_value("portb_pad_oe[3]", portb_pad_oe[3], 1'b1);
      check_value("portb_pad_out[3]", portb_pad_out[3], i[1]);
      check_value("portb_pad_oe[4]", portb_pad_oe[4], 1'b0);
      check_value("spi_rcv", spi_rcv, portb_pad_in[5:2]);
   end
   // Slave, i[0] is ddrx4 and i[1] is the SS pad
   for (i = 0; i < 4; i++) begin
      drive_edge();
      clear_inputs();
      spi.spe         = 1'b1;
      spi.misoo       = 1'b1;
      gpio_b.ddrx     = {1'b1, i[0], 4'b1100};
      r               = next_rand();
      portb_pad_in    = r[5:0];
      portb_pad_in[2] = i[1];
      sample_point();
      check_value("portb_pad_oe[4]", portb_pad_oe[4], i[0] & ~i[1]);
      check_value("portb_pad_out[4]", portb_pad_out[4], 1'b1);
      check_value("portb_pad_oe", portb_pad_oe & 6'b101100, 6'h00);  // SCK, MOSI, SS in
      check_value("spi_rcv", spi_rcv, portb_pad_in[5:2]);
   end
endtask

task automatic test_uart_xck();
   int i;
   for (i = 0; i < 2; i++) begin                        // TXD owns PD1
      drive_edge();
      clear_inputs();
      uart.tx_en      = 1'b1;
      uart.txd        = i[0];
      gpio_d.portx[1] = ~i[0];
      sample_point();
      check_value("portd_pad_oe[1]", portd_pad_oe[1], 1'b1);
      check_value("portd_pad_out[1]", portd_pad_out[1], i[0]);
   end
   for (i = 0; i < 2; i++) begin
      drive_edge();
      clear_inputs();
      uart.rx_en      = 1'b1;
      gpio_d.ddrx[0]  = 1'b1;                           // Overridden to input
      portd_pad_in[0] = i[0];
      sample_point();
      check_value("portd_pad_oe[0]", portd_pad_oe[0], 1'b0);
      check_value("rxd_rcv", rxd_rcv, i[0]);
   end
   for (i = 0; i < 4; i++) begin                        // XCK out, read back on T0
      drive_edge();
      clear_inputs();
      umsel           = 1'b1;
      xcko            = i[0];
      gpio_d.portx[4] = ~i[0];
      gpio_d.ddrx[4]  = 1'b1;
      portd_pad_in[4] = i[1];
      sample_point();
      check_value("portd_pad_out[4]", portd_pad_out[4], i[0]);
      check_value("t0_pin", t0_pin, i[1]);
      check_value("xck_rcv", xck_rcv, i[1]);
   end
endtask

// ==== sim/iomux_tb.sv ====
`timescale 1ns/10ps

module iomux_tb;
   import iomux_pkg::*;

   localparam int NUM_TESTS  = 5;
   localparam int CLK_PERIOD = 40;
   localparam int TIMEOUT_NS = NUM_TESTS * 200 * CLK_PERIOD;   // 200 cycles per test

   logic                 clk;
   logic                 rst_n;
   logic                 sleep;
   gpio_b_t              gpio_b;
   gpio_d_t              gpio_d;
   xb_ovr_t              xb;
   logic [XB_W-1:0]      xb_pinx;
   logic [PCINT_W-1:0]   pcint_irq;
   pcie_t                pcie;
   logic [PCINT_W-1:0]   pcint_rcv;
   spi_ctrl_t            spi;
   spi_rcv_t             spi_rcv;
   oc_t                  oc2a, oc1b, oc1a, oc0a, oc0b, oc2b;
   logic                 icp1_pin, pin13_led;
   uart_ctrl_t           uart;
   logic                 umsel, xcko;
   logic                 xck_rcv, t0_pin, t1_pin;
   logic                 int0_enable, int1_enable;
   logic                 int0_rcv, int1_rcv, rxd_rcv;
   logic [PORTB_W-1:0]   portb_pad_in, portb_pad_oe, portb_pad_out;
   logic [PORTD_W-1:0]   portd_pad_in, portd_pad_oe, portd_pad_out;

   integer seed;                                        // $random state

   iomux_top u_dut (
      .clk (clk), .rst_n (rst_n), .sleep (sleep),
      .gpio_b (gpio_b), .gpio_d (gpio_d), .xb (xb), .xb_pinx (xb_pinx),
      .pcint_irq (pcint_irq), .pcie (pcie), .pcint_rcv (pcint_rcv),
      .spi (spi), .spi_rcv (spi_rcv),
      .oc2a (oc2a), .oc1b (oc1b), .oc1a (oc1a), .oc0a (oc0a), .oc0b (oc0b), .oc2b (oc2b),
      .icp1_pin (icp1_pin), .pin13_led (pin13_led),
      .uart (uart), .umsel (umsel), .xcko (xcko),
      .xck_rcv (xck_rcv), .t0_pin (t0_pin), .t1_pin (t1_pin),
      .int0_enable (int0_enable), .int1_enable (int1_enable),
      .int0_rcv (int0_rcv), .int1_rcv (int1_rcv), .rxd_rcv (rxd_rcv),
      .portb_pad_in (portb_pad_in), .portb_pad_oe (portb_pad_oe),
      .portb_pad_out (portb_pad_out),
      .portd_pad_in (portd_pad_in), .portd_pad_oe (portd_pad_oe),
      .portd_pad_out (portd_pad_out)
   );

   always #(CLK_PERIOD/2) clk = ~clk;                   // 40 ns period

   ////////////////////
   // Watchdog
   ////////////////////

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
      $display("Something failed");
      $fatal(1, "watchdog expired");
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         $display("Something failed");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   task automatic drive_edge();                         // Inputs change 2 ns after rise
      @(posedge clk);
      #2;
   endtask

   task automatic sample_point();                       // Outputs settled mid cycle
      @(negedge clk);
   endtask

   // Idle state, no override and awake
   task automatic clear_inputs();
      sleep        = 1'b0;
      gpio_b       = '0;
      gpio_d       = '0;
      xb           = '0;
      pcint_irq    = '0;
      pcie         = '0;
      spi          = '0;
      oc2a         = '0;
      oc1b         = '0;
      oc1a         = '0;
      oc0a         = '0;
      oc0b         = '0;
      oc2b         = '0;
      uart         = '0;
      umsel        = 1'b0;
      xcko         = 1'b0;
      int0_enable  = 1'b0;
      int1_enable  = 1'b0;
      portb_pad_in = '0;
      portd_pad_in = '0;
   endtask

   `include "iomux_tests.svh"

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      seed        = 32'h09a7_c0ee;
      clk         = 1'b0;
      rst_n       = 1'b0;
      clear_inputs();
      repeat (5) @(posedge clk);                        // Reset for 5 cycles
      #2;
      rst_n = 1'b1;

      test_gpio_default();
      test_sleep_gating();
      test_override_priority();
      test_spi();
      test_uart_xck();

      @(negedge clk);
      $display("Everything OK");
      $finish;
   end

endmodule

// ==== verilog/iomux_pkg.sv ====
package iomux_pkg;

   ////////////////////
   // Widths and offsets
   ////////////////////

   localparam int PORTB_W = 6;               // PB7:6 are the crystal pins on the board
   localparam int PORTD_W = 8;
   localparam int XB_W    = 20;              // Digital 0-13 plus analog 0-5

   localparam int XB_PORTD_LSB = 0;          // D0-D7 sit on port D
   localparam int XB_PORTB_LSB = 8;          // D8-D13 sit on port B

   localparam int PCINT_W         = 24;
   localparam int PCINT_PORTB_LSB = 0;       // PCINT5:0
   localparam int PCINT_PORTD_LSB = 16;      // PCINT23:16

   // INT0 pin takes its pin-change enable from pcie1, as the reference does
   localparam int PORTD_PCINT_PCIE1_BIT = 2;

   ////////////////////
   // Bundles
   ////////////////////

   typedef struct packed {
      logic [PORTB_W-1:0] portx;             // Output value register
      logic [PORTB_W-1:0] ddrx;              // Direction register, 1 = output
   } gpio_b_t;

   typedef struct packed {
      logic [PORTD_W-1:0] portx;
      logic [PORTD_W-1:0] ddrx;
   } gpio_d_t;

   // Accelerator block pin control
   typedef struct packed {
      logic [XB_W-1:0] ddoe;                 // Override direction
      logic [XB_W-1:0] ddov;                 // Direction if overridden
      logic [XB_W-1:0] pvoe;                 // Override output value
      logic [XB_W-1:0] pvov;                 // Value if overridden
   } xb_ovr_t;

   typedef struct packed {
      logic spe;                             // SPI enable
      logic spimaster;
      logic scko;
      logic misoo;
      logic mosio;
   } spi_ctrl_t;

   // Field order matches PB5:2
   typedef struct packed {
      logic scki;
      logic misoi;
      logic mosii;
      logic ss_b;
   } spi_rcv_t;

   typedef struct packed {
      logic enable;                          // Compare output owns the pin
      logic pin;
   } oc_t;

   typedef struct packed {
      logic tx_en;
      logic txd;
      logic rx_en;
   } uart_ctrl_t;

   // Peripheral override set, sized for the wider port
   typedef struct packed {
      logic [PORTD_W-1:0] ddoe;
      logic [PORTD_W-1:0] ddov;
      logic [PORTD_W-1:0] pvoe;
      logic [PORTD_W-1:0] pvov;
      logic [PORTD_W-1:0] dieoe;             // Force input buffer on
   } pin_ovr_t;

   typedef struct packed {
      logic pcie0;                           // Port B pin-change enable
      logic pcie1;
      logic pcie2;                           // Port D pin-change enable
   } pcie_t;

endpackage

// ==== verilog/iomux_top.sv ====
`timescale 1ns/10ps

module iomux_top (
   input  logic                           clk,          // Assertion sampling only
   input  logic                           rst_n,
   input  logic                           sleep,
   input  iomux_pkg::gpio_b_t             gpio_b,
   input  iomux_pkg::gpio_d_t             gpio_d,
   input  iomux_pkg::xb_ovr_t             xb,
   output logic [iomux_pkg::XB_W-1:0]     xb_pinx,
   input  logic [iomux_pkg::PCINT_W-1:0]  pcint_irq,
   input  iomux_pkg::pcie_t               pcie,
   output logic [iomux_pkg::PCINT_W-1:0]  pcint_rcv,
   // Port B functions
   input  iomux_pkg::spi_ctrl_t           spi,
   output iomux_pkg::spi_rcv_t            spi_rcv,
   input  iomux_pkg::oc_t                 oc2a,
   input  iomux_pkg::oc_t                 oc1b,
   input  iomux_pkg::oc_t                 oc1a,
   input  iomux_pkg::oc_t                 oc0a,
   input  iomux_pkg::oc_t                 oc0b,
   input  iomux_pkg::oc_t                 oc2b,
   output logic                           icp1_pin,
   output logic                           pin13_led,
   // Port D functions
   input  iomux_pkg::uart_ctrl_t          uart,
   input  logic                           umsel,
   input  logic                           xcko,
   output logic                           xck_rcv,
   output logic                           t0_pin,
   output logic                           t1_pin,
   input  logic                           int0_enable,
   input  logic                           int1_enable,
   output logic                           int0_rcv,
   output logic                           int1_rcv,
   output logic                           rxd_rcv,
   // Pads, tri-state resolved on the board side
   input  logic [iomux_pkg::PORTB_W-1:0]  portb_pad_in,
   output logic [iomux_pkg::PORTB_W-1:0]  portb_pad_oe,
   output logic [iomux_pkg::PORTB_W-1:0]  portb_pad_out,
   input  logic [iomux_pkg::PORTD_W-1:0]  portd_pad_in,
   output logic [iomux_pkg::PORTD_W-1:0]  portd_pad_oe,
   output logic [iomux_pkg::PORTD_W-1:0]  portd_pad_out
);
   import iomux_pkg::*;

   pin_ovr_t           ovr_b;
   pin_ovr_t           ovr_d;
   logic [PORTB_W-1:0] pinx_b;
   logic [PORTD_W-1:0] pinx_d;
   logic               ss_b_fb;                         // SS read value back to MISO rule

   ////////////////////
   // Port B
   ////////////////////

   port_b_func u_port_b_func (
      .spi         (spi),
      .oc2a        (oc2a),
      .oc1b        (oc1b),
      .oc1a        (oc1a),
      .ss_b        (ss_b_fb),
      .ddrx4       (gpio_b.ddrx[4]),
      .pcint_irq_b (pcint_irq[PCINT_PORTB_LSB +: PORTB_W]),
      .pcie0       (pcie.pcie0),
      .ovr         (ovr_b)
   );

   pin_mux #(.WIDTH(PORTB_W)) u_mux_b (
      .portx   (gpio_b.portx),
      .ddrx    (gpio_b.ddrx),
      .xb_ddoe (xb.ddoe[XB_PORTB_LSB +: PORTB_W]),
      .xb_ddov (xb.ddov[XB_PORTB_LSB +: PORTB_W]),
      .xb_pvoe (xb.pvoe[XB_PORTB_LSB +: PORTB_W]),
      .xb_pvov (xb.pvov[XB_PORTB_LSB +: PORTB_W]),
      .pad_in  (portb_pad_in),
      .ovr     (ovr_b),
      .sleep   (sleep),
      .pad_oe  (portb_pad_oe),
      .pad_out (portb_pad_out),
      .pinx    (pinx_b)
   );

   assign ss_b_fb   = pinx_b[2];                        // PB2 direction never uses it
   assign spi_rcv   = pinx_b[5:2];                      // scki, misoi, mosii, ss_b
   assign icp1_pin  = pinx_b[0];
   assign pin13_led = portb_pad_in[5];                  // Raw pad, not gated by sleep

   ////////////////////
   // Port D
   ////////////////////

   port_d_func u_port_d_func (
      .uart        (uart),
      .umsel       (umsel),
      .xcko        (xcko),
      .oc0a        (oc0a),
      .oc0b        (oc0b),
      .oc2b        (oc2b),
      .int0_enable (int0_enable),
      .int1_enable (int1_enable),
      .pcint_irq_d (pcint_irq[PCINT_PORTD_LSB +: PORTD_W]),
      .pcie        (pcie),
      .ovr         (ovr_d)
   );

   pin_mux #(.WIDTH(PORTD_W)) u_mux_d (
      .portx   (gpio_d.portx),
      .ddrx    (gpio_d.ddrx),
      .xb_ddoe (xb.ddoe[XB_PORTD_LSB +: PORTD_W]),
      .xb_ddov (xb.ddov[XB_PORTD_LSB +: PORTD_W]),
      .xb_pvoe (xb.pvoe[XB_PORTD_LSB +: PORTD_W]),
      .xb_pvov (xb.pvov[XB_PORTD_LSB +: PORTD_W]),
      .pad_in  (portd_pad_in),
      .ovr     (ovr_d),
      .sleep   (sleep),
      .pad_oe  (portd_pad_oe),
      .pad_out (portd_pad_out),
      .pinx    (pinx_d)
   );

   assign t1_pin   = pinx_d[5];
   assign xck_rcv  = pinx_d[4];                         // XCK and T0 share PD4
   assign t0_pin   = pinx_d[4];
   assign int1_rcv = pinx_d[3];
   assign int0_rcv = pinx_d[2];
   assign rxd_rcv  = pinx_d[0];

   // Pin-change and xb read-back, unused bits read zero
   always_comb begin
      pcint_rcv = '0;
      pcint_rcv[PCINT_PORTB_LSB +: PORTB_W] = pinx_b;
      pcint_rcv[PCINT_PORTD_LSB +: PORTD_W] = pinx_d;

      xb_pinx = '0;                                     // Analog 0-5 have no port here
      xb_pinx[XB_PORTB_LSB +: PORTB_W] = portb_pad_in;
      xb_pinx[XB_PORTD_LSB +: PORTD_W] = portd_pad_in;
   end

endmodule

// ==== verilog/pin_mux.sv ====
`timescale 1ns/10ps

module pin_mux #(
   parameter int WIDTH = 8                        // At most the override width of 8
) (
   input  logic [WIDTH-1:0]      portx,
   input  logic [WIDTH-1:0]      ddrx,
   input  logic [WIDTH-1:0]      xb_ddoe,
   input  logic [WIDTH-1:0]      xb_ddov,
   input  logic [WIDTH-1:0]      xb_pvoe,
   input  logic [WIDTH-1:0]      xb_pvov,
   input  logic [WIDTH-1:0]      pad_in,
   input  iomux_pkg::pin_ovr_t   ovr,
   input  logic                  sleep,
   output logic [WIDTH-1:0]      pad_oe,
   output logic [WIDTH-1:0]      pad_out,
   output logic [WIDTH-1:0]      pinx
);

   logic [WIDTH-1:0] p_ddoe;
   logic [WIDTH-1:0] p_ddov;
   logic [WIDTH-1:0] p_pvoe;
   logic [WIDTH-1:0] p_pvov;
   logic [WIDTH-1:0] in_en;

   // Peripheral set is 8 wide, take this port's pins
   assign p_ddoe = ovr.ddoe[WIDTH-1:0];
   assign p_ddov = ovr.ddov[WIDTH-1:0];
   assign p_pvoe = ovr.pvoe[WIDTH-1:0];
   assign p_pvov = ovr.pvov[WIDTH-1:0];

   ////////////////////
   // And-or priority mux
   ////////////////////

   // Register path only when neither override is active
   assign pad_oe  = (xb_ddoe & xb_ddov) |
                    (p_ddoe & p_ddov) |
                    (~(xb_ddoe | p_ddoe) & ddrx);
   assign pad_out = (xb_pvoe & xb_pvov) |
                    (p_pvoe & p_pvov) |
                    (~(xb_pvoe | p_pvoe) & portx);

   // Input buffer on when awake or held on by an interrupt source
   assign in_en = ovr.dieoe[WIDTH-1:0] | {WIDTH{~sleep}};
   assign pinx  = pad_in & in_en;

endmodule

// ==== verilog/port_b_func.sv ====
`timescale 1ns/10ps

module port_b_func (
   input  iomux_pkg::spi_ctrl_t           spi,
   input  iomux_pkg::oc_t                 oc2a,
   input  iomux_pkg::oc_t                 oc1b,
   input  iomux_pkg::oc_t                 oc1a,
   input  logic                           ss_b,         // PB2 read value
   input  logic                           ddrx4,        // MISO direction register bit
   input  logic [iomux_pkg::PORTB_W-1:0]  pcint_irq_b,  // PCINT5:0 mask
   input  logic                           pcie0,
   output iomux_pkg::pin_ovr_t            ovr
);
   import iomux_pkg::*;

   logic spi_master;
   logic spi_slave;

   assign spi_master = spi.spe & spi.spimaster;
   assign spi_slave  = spi.spe & ~spi.spimaster;

   ////////////////////
   // Port B overrides
   ////////////////////

   always_comb begin
      ovr = '0;                                         // Bits 7:6 stay clear

      // PB5 SCK
      ovr.ddoe[5] = spi.spe;
      ovr.ddov[5] = spi.spimaster;                      // Output as master, input as slave
      ovr.pvoe[5] = spi_master;
      ovr.pvov[5] = spi.scko;

      // PB4 MISO
      // A slave keeps MISO tri-stated while SS is high
      ovr.ddoe[4] = spi.spe;
      ovr.ddov[4] = spi.spimaster ? 1'b0 : (ddrx4 & ~ss_b);
      ovr.pvoe[4] = spi_slave;
      ovr.pvov[4] = spi.misoo;

      // PB3 MOSI, shared with OC2A
      ovr.ddoe[3] = spi_slave;                          // Forced input in slave mode
      ovr.ddov[3] = 1'b0;
      ovr.pvoe[3] = spi_master | oc2a.enable;
      ovr.pvov[3] = (spi.spe & spi.mosio) | oc2a.pin;   // Values or'ed together

      // PB2 SS, shared with OC1B
      ovr.ddoe[2] = spi_slave;
      ovr.ddov[2] = 1'b0;
      ovr.pvoe[2] = oc1b.enable;
      ovr.pvov[2] = oc1b.pin;

      // PB1 OC1A
      ovr.pvoe[1] = oc1a.enable;
      ovr.pvov[1] = oc1a.pin;

      // PB0 is ICP1, input only, so it has no output override

      // Masked pin-change pins keep their input buffer alive in sleep
      ovr.dieoe[PORTB_W-1:0] = pcint_irq_b & {PORTB_W{pcie0}};
   end

endmodule

// ==== verilog/port_d_func.sv ====
`timescale 1ns/10ps

module port_d_func (
   input  iomux_pkg::uart_ctrl_t          uart,
   input  logic                           umsel,        // USART in sync master mode
   input  logic                           xcko,
   input  iomux_pkg::oc_t                 oc0a,
   input  iomux_pkg::oc_t                 oc0b,
   input  iomux_pkg::oc_t                 oc2b,
   input  logic                           int0_enable,
   input  logic                           int1_enable,
   input  logic [iomux_pkg::PORTD_W-1:0]  pcint_irq_d,  // PCINT23:16 mask
   input  iomux_pkg::pcie_t               pcie,
   output iomux_pkg::pin_ovr_t            ovr
);
   import iomux_pkg::*;

   logic [PORTD_W-1:0] pc_en;                           // Pin-change enable per pin

   // Every pin follows pcie2 except the INT0 pin
   always_comb begin
      pc_en = {PORTD_W{pcie.pcie2}};
      pc_en[PORTD_PCINT_PCIE1_BIT] = pcie.pcie1;
   end

   ////////////////////
   // Port D overrides
   ////////////////////

   always_comb begin
      ovr = '0;

      // PD7 has no peripheral function here

      ovr.pvoe[6] = oc0a.enable;                        // OC0A
      ovr.pvov[6] = oc0a.pin;
      ovr.pvoe[5] = oc0b.enable;                        // OC0B, T1 input
      ovr.pvov[5] = oc0b.pin;
      ovr.pvoe[4] = umsel;                              // XCK out, T0 input
      ovr.pvov[4] = xcko;
      ovr.pvoe[3] = oc2b.enable;                        // OC2B, INT1 input
      ovr.pvov[3] = oc2b.pin;

      // PD2 is INT0, input only

      // PD1 TXD
      ovr.ddoe[1] = uart.tx_en;
      ovr.ddov[1] = 1'b1;                               // Transmitter owns the pin
      ovr.pvoe[1] = uart.tx_en;
      ovr.pvov[1] = uart.txd;

      // PD0 RXD
      ovr.ddoe[0] = uart.rx_en;
      ovr.ddov[0] = 1'b0;

      ovr.dieoe = pcint_irq_d & pc_en;
      ovr.dieoe[3] = ovr.dieoe[3] | int1_enable;        // INT1 must see the pin in sleep
      ovr.dieoe[2] = ovr.dieoe[2] | int0_enable;        // Same for INT0
   end

endmodule
